/* compile.f */
+incdir+source
source/cpuPkg.sv
source/cpuCmd.sv
source/cpuNxm.sv
source/cpuTimer.sv
source/cpuApr.sv
source/cpuPi.sv
source/cpuIntf.sv
source/cpu.sv
verification/tbCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tbCpu -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VtbCpu > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

/* source/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
   input  wire                     clk,
   input  wire                     rstN,
   // Command port
   input  wire                     cmdValid,
   output wire                     cmdReady,
   input  wire cpuPkg::cmdOp       cmdOp,
   input  wire cpuPkg::addrWord    cmdAddr,
   input  wire cpuPkg::dataWord    cmdData,
   output wire                     rspValid,
   output wire cpuPkg::dataWord    rspData,
   output wire                     rspNxm,
   // CPU bus
   output wire                     cpuREQO,     // Bus request
   input  wire                     cpuACKI,     // Bus acknowledge
   output wire                     cpuWRO,      // Write cycle
   output wire cpuPkg::addrWord    cpuADDRO,
   output wire cpuPkg::dataWord    cpuDATAO,
   input  wire cpuPkg::dataWord    cpuDATAI,
   // Unibus
   input  wire cpuPkg::intrVec     ubaINTR,     // Unibus interrupt requests
   // Console
   input  wire                     cslRUN,
   input  wire                     cslHALT,
   input  wire                     cslCONT,
   input  wire                     cslEXEC,
   input  wire                     debugHALT,   // Breakpoint
   input  wire                     cslTIMEREN,  // Timer enable
   input  wire                     cslINTRI,    // Console to CPU
   output wire                     cslINTRO,    // CPU to console
   output wire                     cpuRUN,
   output wire                     cpuHALT,
   output wire                     cpuCONT,
   output wire                     cpuEXEC,
   // Status
   output wire cpuPkg::aprFlags    aprFLAGS,
   output wire                     piINTR,
   output wire cpuPkg::piLevel     piREQPRI,
   output wire cpuPkg::piLevel     piCURPRI
);

   //////////////////////////////////////////////////////////////////////////
   // Internal nets

   wire                  nxmAbort;             // Watchdog abort
   wire                  timerTick;            // Interval tick
   wire cpuPkg::intrVec  aprINTR;              // APR request one-hot
   wire                  aprWrite;
   wire                  aprClear;
   wire                  piEnable;
   wire                  piGrant;
   wire                  piDismiss;
   wire cpuPkg::dataWord ctlData;              // Register load payload

   //////////////////////////////////////////////////////////////////////////
   // Blocks

   cpuCmd uCmd (
      .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .cmdReady(cmdReady),
      .cmdOp(cmdOp), .cmdAddr(cmdAddr), .cmdData(cmdData),
      .rspValid(rspValid), .rspData(rspData), .rspNxm(rspNxm),
      .cpuREQO(cpuREQO), .cpuACKI(cpuACKI), .cpuWRO(cpuWRO),
      .cpuADDRO(cpuADDRO), .cpuDATAO(cpuDATAO), .cpuDATAI(cpuDATAI),
      .nxmAbort(nxmAbort), .aprWrite(aprWrite), .aprClear(aprClear),
      .piEnable(piEnable), .piGrant(piGrant), .piDismiss(piDismiss),
      .ctlData(ctlData)
   );

   cpuNxm uNxm (
      .clk(clk), .rstN(rstN), .cpuREQO(cpuREQO), .cpuACKI(cpuACKI),
      .nxmAbort(nxmAbort)
   );

   // Timer only runs with the console enable
   cpuTimer uTimer (
      .clk(clk), .rstN(rstN), .timerEn(cslTIMEREN), .cpuRUN(cpuRUN),
      .timerTick(timerTick)
   );

   cpuApr uApr (
      .clk(clk), .rstN(rstN), .nxmAbort(nxmAbort), .timerTick(timerTick),
      .cslINTRI(cslINTRI), .aprWrite(aprWrite), .aprClear(aprClear),
      .ctlData(ctlData), .aprFLAGS(aprFLAGS), .aprINTR(aprINTR),
      .cslINTRO(cslINTRO)
   );

   cpuPi uPi (
      .clk(clk), .rstN(rstN), .aprINTR(aprINTR), .ubaINTR(ubaINTR),
      .piEnable(piEnable), .piGrant(piGrant), .piDismiss(piDismiss),
      .ctlData(ctlData), .piINTR(piINTR), .piREQPRI(piREQPRI),
      .piCURPRI(piCURPRI)
   );

   cpuIntf uIntf (
      .clk(clk), .rstN(rstN), .cslRUN(cslRUN), .cslHALT(cslHALT),
      .cslCONT(cslCONT), .cslEXEC(cslEXEC), .debugHALT(debugHALT),
      .cpuRUN(cpuRUN), .cpuHALT(cpuHALT), .cpuCONT(cpuCONT), .cpuEXEC(cpuEXEC)
   );

endmodule

`default_nettype wire

/* source/cpuApr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuApr (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire                     nxmAbort,    // Watchdog event
   input  wire                     timerTick,   // Timer event
   input  wire                     cslINTRI,    // Console event
   input  wire                     aprWrite,
   input  wire                     aprClear,
   input  wire cpuPkg::dataWord    ctlData,
   output cpuPkg::aprFlags         aprFLAGS,
   output cpuPkg::intrVec          aprINTR,
   output logic                    cslINTRO
);

   cpuPkg::aprFlags aprEnable;                // Interrupt enables per flag
   cpuPkg::piLevel  aprLevel;                 // Level for APR requests
   cpuPkg::aprFlags setMask;
   cpuPkg::aprFlags clrMask;

   // Event to flag mapping
   always_comb
   begin
      setMask                  = '0;
      setMask[`CPU_FLAG_NXM]   = nxmAbort;
      setMask[`CPU_FLAG_TIMER] = timerTick;
      setMask[`CPU_FLAG_CSL]   = cslINTRI;
   end

   assign clrMask = aprClear ? ctlData[`CPU_FLAG_COUNT-1:0] : '0;

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         aprFLAGS  <= '0;
         aprEnable <= '0;
         aprLevel  <= '0;
         cslINTRO  <= 1'b0;
      end
      else
      begin
         aprFLAGS <= (aprFLAGS & ~clrMask) | setMask;   // Set wins
         if (aprWrite)
         begin
            aprEnable <= ctlData[2:0];
            aprLevel  <= ctlData[5:3];
            cslINTRO  <= ctlData[6];
         end
      end
   end

   // One-hot request at the programmed level
   assign aprINTR = ((|(aprFLAGS & aprEnable)) && (aprLevel != '0)) ?
                    cpuPkg::intrVec'(1) << (aprLevel - 3'd1) : '0;

endmodule

`default_nettype wire

/* source/cpuCmd.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCmd (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire                     cmdValid,
   output logic                    cmdReady,
   input  wire cpuPkg::cmdOp       cmdOp,
   input  wire cpuPkg::addrWord    cmdAddr,
   input  wire cpuPkg::dataWord    cmdData,
   output logic                    rspValid,
   output cpuPkg::dataWord         rspData,
   output logic                    rspNxm,
   output logic                    cpuREQO,
   input  wire                     cpuACKI,
   output logic                    cpuWRO,
   output cpuPkg::addrWord         cpuADDRO,
   output cpuPkg::dataWord         cpuDATAO,
   input  wire cpuPkg::dataWord    cpuDATAI,
   input  wire                     nxmAbort,
   output logic                    aprWrite,
   output logic                    aprClear,
   output logic                    piEnable,
   output logic                    piGrant,
   output logic                    piDismiss,
   output cpuPkg::dataWord         ctlData
);

   cpuPkg::busState busSt;
   logic            cmdFire;                  // Command accepted this edge
   logic            busCmd;                   // Read or write
   logic            busEnd;                   // Ack or abort ends the cycle

   assign cmdReady = (busSt != cpuPkg::busReq); // Busy only while requesting
   assign cmdFire  = cmdValid && cmdReady;
   assign busCmd   = (cmdOp == cpuPkg::opRead) || (cmdOp == cpuPkg::opWrite);
   assign busEnd   = cpuREQO && (cpuACKI || nxmAbort);

   // Register load strobes land on the acceptance edge
   assign aprWrite  = cmdFire && (cmdOp == cpuPkg::opAprWrite);
   assign aprClear  = cmdFire && (cmdOp == cpuPkg::opAprClear);
   assign piEnable  = cmdFire && (cmdOp == cpuPkg::opPiEnable);
   assign piGrant   = cmdFire && (cmdOp == cpuPkg::opPiGrant);
   assign piDismiss = cmdFire && (cmdOp == cpuPkg::opPiDismiss);
   assign ctlData   = cmdData;

   assign cpuREQO  = (busSt == cpuPkg::busReq);
   assign rspValid = (busSt == cpuPkg::busDone);  // One cycle response

   // Bus cycle sequencer
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         busSt <= cpuPkg::busIdle;
      else if (busSt == cpuPkg::busReq)
      begin
         if (busEnd)
            busSt <= cpuPkg::busDone;
      end
      else if (cmdFire && busCmd)
         busSt <= cpuPkg::busReq;          // Done also takes a new command
      else
         busSt <= cpuPkg::busIdle;
   end

   // Address, data and response
   always_ff @(posedge clk)
   begin
      if (cmdFire && busCmd)
      begin
         cpuADDRO <= cmdAddr;
         cpuDATAO <= cmdData;
         cpuWRO   <= (cmdOp == cpuPkg::opWrite);
      end
      if (busEnd)
      begin
         rspData <= (cpuACKI && !cpuWRO) ? cpuDATAI : '0;  // Zero on write or abort
         rspNxm  <= !cpuACKI;                              // Ack beats abort
      end
   end

   // Address held until the slave answers or the watchdog fires
   reqAddrStable: assert property (@(posedge clk) disable iff (!rstN)
      (cpuREQO && !cpuACKI && !nxmAbort) |=> (cpuREQO && $stable(cpuADDRO)));

endmodule

`default_nettype wire

/* source/cpuIntf.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuIntf (
   input  wire   clk,
   input  wire   rstN,
   input  wire   cslRUN,                      // Console run
   input  wire   cslHALT,                     // Console halt
   input  wire   cslCONT,                     // Console continue
   input  wire   cslEXEC,                     // Console execute
   input  wire   debugHALT,                   // Breakpoint halt
   output logic  cpuRUN,
   output logic  cpuHALT,
   output logic  cpuCONT,                     // One cycle pulse
   output logic  cpuEXEC                      // One cycle pulse
);

   cpuPkg::cslState cslSt;
   logic            haltReq;

   assign haltReq = cslHALT || debugHALT;    // Halt beats everything

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         cslSt   <= cpuPkg::cslHalted;
         cpuCONT <= 1'b0;
         cpuEXEC <= 1'b0;
      end
      else
      begin
         cpuCONT <= 1'b0;
         cpuEXEC <= 1'b0;
         if (cslSt == cpuPkg::cslRunning)
         begin
            if (haltReq)
               cslSt <= cpuPkg::cslHalted;
         end
         else if (!haltReq)
         begin
            if (cslCONT)
            begin
               cpuCONT <= 1'b1;
               cslSt   <= cpuPkg::cslRunning;
            end
            else if (cslRUN)
               cslSt <= cpuPkg::cslRunning;
            else if (cslEXEC)
               cpuEXEC <= 1'b1;            // Single step, stays halted
         end
      end
   end

   assign cpuRUN  = (cslSt == cpuPkg::cslRunning);
   assign cpuHALT = (cslSt == cpuPkg::cslHalted);

endmodule

`default_nettype wire

/* source/cpuNxm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuNxm (
   input  wire   clk,
   input  wire   rstN,
   input  wire   cpuREQO,                     // Bus request
   input  wire   cpuACKI,                     // Bus acknowledge
   output logic  nxmAbort                     // Abort pulse
);

   localparam int CntW = $clog2(`CPU_NXM_TIMEOUT);

   logic [CntW-1:0] waitCnt;                  // Unanswered cycles so far
   logic            waiting;

   assign waiting  = cpuREQO && !cpuACKI;
   // Fires in the last allowed cycle of the request
   assign nxmAbort = waiting && (waitCnt == CntW'(`CPU_NXM_TIMEOUT - 1));

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         waitCnt <= '0;
      else if (!waiting || nxmAbort)
         waitCnt <= '0;                       // Ack, idle or abort restarts
      else
         waitCnt <= waitCnt + CntW'(1);
   end

   // Abort only during a request, and the sequencer drops it next cycle
   abortInReq: assert property (@(posedge clk) disable iff (!rstN)
      nxmAbort |-> cpuREQO ##1 !cpuREQO);

endmodule

`default_nettype wire

/* source/cpuPi.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuPi (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire cpuPkg::intrVec     aprINTR,     // From APR
   input  wire cpuPkg::intrVec     ubaINTR,     // From Unibus
   input  wire                     piEnable,
   input  wire                     piGrant,
   input  wire                     piDismiss,
   input  wire cpuPkg::dataWord    ctlData,
   output logic                    piINTR,
   output cpuPkg::piLevel          piREQPRI,
   output cpuPkg::piLevel          piCURPRI
);

   cpuPkg::intrVec piMask;                    // Level enables
   cpuPkg::intrVec piActive;                  // Levels in service
   cpuPkg::intrVec piReq;                     // Enabled requests

   assign piReq = (aprINTR | ubaINTR) & piMask;

   // Lowest numbered level wins, so scan from the bottom up
   always_comb
   begin
      piREQPRI = '0;
      piCURPRI = '0;
      for (int k = 7; k >= 1; k--)
      begin
         if (piReq[k-1])
            piREQPRI = cpuPkg::piLevel'(k);
         if (piActive[k-1])
            piCURPRI = cpuPkg::piLevel'(k);
      end
   end

   // Interrupt only above the level in service
   assign piINTR = (piREQPRI != '0) && ((piCURPRI == '0) || (piREQPRI < piCURPRI));

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         piMask   <= '0;
         piActive <= '0;
      end
      else
      begin
         if (piEnable)
            piMask <= ctlData[6:0];
         if (piGrant && piINTR)
            piActive[piREQPRI - 3'd1] <= 1'b1;  // Enter new level
         if (piDismiss && (piCURPRI != '0))
            piActive[piCURPRI - 3'd1] <= 1'b0;  // Back to previous level
      end
   end

   // Grant needs a pending interrupt and makes it the current level
   grantTaken: assert property (@(posedge clk) disable iff (!rstN)
      piGrant |-> piINTR ##1 (piCURPRI == $past(piREQPRI)));

endmodule

`default_nettype wire

/* source/cpuPkg.sv */
`default_nettype none

package cpuPkg;

   // Bus widths
   typedef logic [35:0] dataWord;    // 36-bit data word
   typedef logic [19:0] addrWord;    // Physical address

   // Interrupt system
   typedef logic [2:0]  piLevel;     // 1 highest, 7 lowest, 0 none
   typedef logic [6:0]  intrVec;     // Bit k-1 requests level k
   typedef logic [2:0]  aprFlags;    // nxm, timer, console-in

   // Command port opcodes
   typedef enum logic [2:0] {
      opRead      = 3'd0,            // Bus read
      opWrite     = 3'd1,            // Bus write
      opAprWrite  = 3'd2,            // Load APR enables, level, cslINTRO
      opAprClear  = 3'd3,            // Clear APR flags by mask
      opPiEnable  = 3'd4,            // Load PI level enables
      opPiGrant   = 3'd5,            // Take the requested level
      opPiDismiss = 3'd6             // Drop the current level
   } cmdOp;

   // Bus cycle sequencer
   typedef enum logic [1:0] {
      busIdle,
      busReq,
      busDone
   } busState;

   // Console run state
   typedef enum logic {
      cslHalted,
      cslRunning
   } cslState;

endpackage

`default_nettype wire

/* source/cpuTimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpuTimer (
   input  wire   clk,
   input  wire   rstN,
   input  wire   timerEn,                     // Console timer enable
   input  wire   cpuRUN,                      // Counts only while running
   output logic  timerTick                    // One cycle per period
);

   localparam int CntW = $clog2(`CPU_TIMER_PERIOD);

   logic [CntW-1:0] tickCnt;
   logic            counting;

   assign counting  = timerEn && cpuRUN;
   assign timerTick = counting && (tickCnt == CntW'(`CPU_TIMER_PERIOD - 1));

   // Modulo period counter, frozen while halted or disabled
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         tickCnt <= '0;
      else if (timerTick)
         tickCnt <= '0;                       // Wrap
      else if (counting)
         tickCnt <= tickCnt + CntW'(1);
   end

endmodule

`default_nettype wire

/* source/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus watchdog
`define CPU_NXM_TIMEOUT  16          // Cycles before an unanswered request aborts

// Interval timer
`define CPU_TIMER_PERIOD 50          // Running cycles per tick

//////////////////////////////////////////////////////////////////////////////
// APR flag bit positions

`define CPU_FLAG_NXM     0           // Non-existent memory
`define CPU_FLAG_TIMER   1           // Interval timer
`define CPU_FLAG_CSL     2           // Console interrupt in

// Flag set width follows the highest position
`define CPU_FLAG_COUNT   3

`endif

/* verification/tbCpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tbCpu;

   localparam int NumRows = 17;
   localparam int Never   = -1;                 // Slave never answers
   localparam int TimeoutCycles =
      NumRows * (`CPU_NXM_TIMEOUT + `CPU_TIMER_PERIOD + 20);
   localparam cpuPkg::aprFlags NxmFlag = cpuPkg::aprFlags'(1 << `CPU_FLAG_NXM);
   localparam cpuPkg::aprFlags CslFlag = cpuPkg::aprFlags'(1 << `CPU_FLAG_CSL);

   logic            clk, rstN;
   logic            cmdValid, cmdReady, rspValid, rspNxm;
   cpuPkg::cmdOp    cmdOp;
   cpuPkg::addrWord cmdAddr, cpuADDRO;
   cpuPkg::dataWord cmdData, rspData, cpuDATAO, cpuDATAI;
   logic            cpuREQO, cpuACKI, cpuWRO;
   cpuPkg::intrVec  ubaINTR;
   logic            cslRUN, cslHALT, cslCONT, cslEXEC, debugHALT, cslTIMEREN, cslINTRI;
   logic            cslINTRO, cpuRUN, cpuHALT, cpuCONT, cpuEXEC, piINTR;
   cpuPkg::aprFlags aprFLAGS;
   cpuPkg::piLevel  piREQPRI, piCURPRI;

   // Stimulus and expected values, one entry per row
   string           tName [NumRows];
   cpuPkg::cmdOp    tOp   [NumRows];
   cpuPkg::addrWord tAddr [NumRows];
   cpuPkg::dataWord tData [NumRows];
   int              tDelay[NumRows];            // Ack delay or Never
   cpuPkg::intrVec  tUba  [NumRows];
   cpuPkg::dataWord tRsp  [NumRows];
   logic            tNxm  [NumRows];
   cpuPkg::aprFlags tFlags[NumRows];
   cpuPkg::piLevel  tReq  [NumRows];
   cpuPkg::piLevel  tCur  [NumRows];
   logic            tIntr [NumRows];
   int              rowCnt;
   cpuPkg::dataWord lastData;                   // Response of the last bus command
   logic            lastNxm;

   cpu dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   //////////////////////////////////////////////////////////////////////////
   // Memory model data

   // 32-bit Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Fixed word per address, one LFSR step per data bit
   function automatic cpuPkg::dataWord memWord(input cpuPkg::addrWord addr);
      logic [31:0]     s;
      cpuPkg::dataWord w;
      int              b;
      s = 32'd99 ^ {4'd0, addr, 8'd0};          // Low byte keeps the state nonzero
      w = '0;
      for (b = 0; b < 36; b++)
      begin
         s = lfsrNext(s);
         w = {w[34:0], s[0]};
      end
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic reportFail(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic checkWord(input string name, input cpuPkg::dataWord exp,
                            input cpuPkg::dataWord act);
      if (act !== exp)
         reportFail($sformatf("error %s: expected %h, got %h", name, exp, act));
   endtask

   task automatic checkAddr(input string name, input cpuPkg::addrWord exp,
                            input cpuPkg::addrWord act);
      if (act !== exp)
         reportFail($sformatf("error %s: expected %h, got %h", name, exp, act));
   endtask

   task automatic checkLevel(input string name, input cpuPkg::piLevel exp,
                             input cpuPkg::piLevel act);
      if (act !== exp)
         reportFail($sformatf("error %s: expected %0d, got %0d", name, exp, act));
   endtask

   task automatic checkFlags(input string name, input cpuPkg::aprFlags exp,
                             input cpuPkg::aprFlags act);
      if (act !== exp)
         reportFail($sformatf("error %s: expected %b, got %b", name, exp, act));
   endtask

   task automatic checkBit(input string name, input logic exp, input logic act);
      if (act !== exp)
         reportFail($sformatf("error %s: expected %b, got %b", name, exp, act));
   endtask

   // Cycle counts
   task automatic checkCount(input string name, input int exp, input int act);
      if (act != exp)
         reportFail($sformatf("error %s: expected %0d, got %0d", name, exp, act));
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Drivers

   task automatic addRow(input string name, input cpuPkg::cmdOp op,
                         input cpuPkg::addrWord addr, input cpuPkg::dataWord data,
                         input int delay, input cpuPkg::intrVec uba,
                         input cpuPkg::dataWord rsp, input logic nxm,
                         input cpuPkg::aprFlags flags, input cpuPkg::piLevel req,
                         input cpuPkg::piLevel cur, input logic intr);
      tName[rowCnt]  = name;
      tOp[rowCnt]    = op;
      tAddr[rowCnt]  = addr;
      tData[rowCnt]  = data;
      tDelay[rowCnt] = delay;
      tUba[rowCnt]   = uba;
      tRsp[rowCnt]   = rsp;
      tNxm[rowCnt]   = nxm;
      tFlags[rowCnt] = flags;
      tReq[rowCnt]   = req;
      tCur[rowCnt]   = cur;
      tIntr[rowCnt]  = intr;
      rowCnt++;
   endtask

   // One command through the valid/ready port, bus slave included
   task automatic sendCmd(input string name, input cpuPkg::cmdOp op,
                          input cpuPkg::addrWord addr, input cpuPkg::dataWord data,
                          input int delay);
      logic isBus;
      logic isWrite;
      int   reqCycles;
      isBus    = (op == cpuPkg::opRead) || (op == cpuPkg::opWrite);
      isWrite  = (op == cpuPkg::opWrite);
      lastData = '0;
      lastNxm  = 1'b0;
      @(posedge clk);
      cmdValid <= 1'b1;
      cmdOp    <= op;
      cmdAddr  <= addr;
      cmdData  <= data;
      @(negedge clk);
      while (!cmdReady)
         @(negedge clk);
      @(posedge clk);                           // Acceptance edge
      cmdValid <= 1'b0;
      if (!isBus)
      begin
         @(negedge clk);                        // Register already loaded
         checkBit({name, " cmdReady kept"}, 1'b1, cmdReady);
      end
      else
      begin
         if (delay == 0)
         begin
            cpuACKI  <= 1'b1;
            cpuDATAI <= memWord(addr);
         end
         else if (delay == Never)
            cpuDATAI <= memWord(addr);          // Stray data with no ack
         @(negedge clk);
         checkBit({name, " cpuREQO"}, 1'b1, cpuREQO);
         checkBit({name, " cmdReady busy"}, 1'b0, cmdReady);
         checkAddr({name, " cpuADDRO"}, addr, cpuADDRO);
         checkBit({name, " cpuWRO"}, isWrite, cpuWRO);
         if (isWrite)
            checkWord({name, " cpuDATAO"}, data, cpuDATAO);
         reqCycles = 1;                         // Request cycle seen above
         if (delay > 0)
         begin
            repeat (delay)
               @(posedge clk);
            cpuACKI  <= 1'b1;
            cpuDATAI <= memWord(addr);
         end
         if (delay != Never)
         begin
            @(posedge clk);                     // Ack edge
            cpuACKI  <= 1'b0;
            cpuDATAI <= '0;
         end
         @(negedge clk);
         while (!rspValid)                      // Watchdog catches a lost response
         begin
            if (cpuREQO)
               reqCycles++;
            @(negedge clk);
         end
         checkBit({name, " cmdReady back"}, 1'b1, cmdReady);
         lastData = rspData;
         lastNxm  = rspNxm;
         if (delay == Never)
            checkCount({name, " abort cycle"}, `CPU_NXM_TIMEOUT, reqCycles);
         @(negedge clk);
         checkBit({name, " rspValid pulse"}, 1'b0, rspValid);
      end
   endtask

   // Console inputs held for one edge
   task automatic consolePulse(input logic run, input logic halt, input logic cont,
                               input logic exec, input logic dbg);
      @(posedge clk);
      cslRUN    <= run;
      cslHALT   <= halt;
      cslCONT   <= cont;
      cslEXEC   <= exec;
      debugHALT <= dbg;
      @(posedge clk);
      cslRUN    <= 1'b0;
      cslHALT   <= 1'b0;
      cslCONT   <= 1'b0;
      cslEXEC   <= 1'b0;
      debugHALT <= 1'b0;
      @(negedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Table: name op addr data delay uba | rspData nxm flags req cur intr

   task automatic buildTable();
      addRow("rdAck0", cpuPkg::opRead, 20'h00010, 36'h0, 0, 7'h00,
             memWord(20'h00010), 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      addRow("rdAck3", cpuPkg::opRead, 20'h0ABCD, 36'h0, 3, 7'h00,
             memWord(20'h0ABCD), 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      addRow("rdAck5", cpuPkg::opRead, 20'hFFFFF, 36'h0, 5, 7'h00,
             memWord(20'hFFFFF), 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      addRow("wrAck1", cpuPkg::opWrite, 20'h00200, 36'h987654321, 1, 7'h00,
             36'h0, 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      addRow("rdAck2", cpuPkg::opRead, 20'h00200, 36'h0, 2, 7'h00,
             memWord(20'h00200), 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      // Dead addresses, watchdog aborts
      addRow("wrNever", cpuPkg::opWrite, 20'h40000, 36'hF0000000F, Never, 7'h00,
             36'h0, 1'b1, NxmFlag, 3'd0, 3'd0, 1'b0);
      addRow("rdNever", cpuPkg::opRead, 20'h40004, 36'h0, Never, 7'h00,
             36'h0, 1'b1, NxmFlag, 3'd0, 3'd0, 1'b0);
      // APR nxm at level 3
      addRow("aprEnable", cpuPkg::opAprWrite, 20'h0, 36'h19, 0, 7'h00,
             36'h0, 1'b0, NxmFlag, 3'd0, 3'd0, 1'b0);
      addRow("piEnable3", cpuPkg::opPiEnable, 20'h0, 36'h04, 0, 7'h00,
             36'h0, 1'b0, NxmFlag, 3'd3, 3'd0, 1'b1);
      addRow("aprClear", cpuPkg::opAprClear, 20'h0, 36'h1, 0, 7'h00,
             36'h0, 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
      // Unibus levels 5 and 7, then 2 on top
      addRow("ubaEnable", cpuPkg::opPiEnable, 20'h0, 36'h7F, 0, 7'b1010000,
             36'h0, 1'b0, 3'b000, 3'd5, 3'd0, 1'b1);
      addRow("grant5", cpuPkg::opPiGrant, 20'h0, 36'h0, 0, 7'b1010000,
             36'h0, 1'b0, 3'b000, 3'd5, 3'd5, 1'b0);
      addRow("raise2", cpuPkg::opPiEnable, 20'h0, 36'h7F, 0, 7'b1010010,
             36'h0, 1'b0, 3'b000, 3'd2, 3'd5, 1'b1);
      addRow("grant2", cpuPkg::opPiGrant, 20'h0, 36'h0, 0, 7'b1010010,
             36'h0, 1'b0, 3'b000, 3'd2, 3'd2, 1'b0);
      addRow("dismiss2", cpuPkg::opPiDismiss, 20'h0, 36'h0, 0, 7'b1010000,
             36'h0, 1'b0, 3'b000, 3'd5, 3'd5, 1'b0);
      addRow("dismiss5", cpuPkg::opPiDismiss, 20'h0, 36'h0, 0, 7'b1010000,
             36'h0, 1'b0, 3'b000, 3'd5, 3'd0, 1'b1);
      addRow("piOff", cpuPkg::opPiEnable, 20'h0, 36'h0, 0, 7'h00,
             36'h0, 1'b0, 3'b000, 3'd0, 3'd0, 1'b0);
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Console, timer and console flags

   task automatic consoleSequence();
      checkBit("csl start cpuHALT", 1'b1, cpuHALT);
      consolePulse(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);       // Run
      checkBit("csl run cpuRUN", 1'b1, cpuRUN);
      checkBit("csl run cpuHALT", 1'b0, cpuHALT);
      consolePulse(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);       // Halt
      checkBit("csl halt cpuHALT", 1'b1, cpuHALT);
      checkBit("csl halt cpuRUN", 1'b0, cpuRUN);
      consolePulse(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);       // Execute
      checkBit("csl exec cpuEXEC", 1'b1, cpuEXEC);
      checkBit("csl exec cpuHALT", 1'b1, cpuHALT);
      @(negedge clk);
      checkBit("csl exec pulse end", 1'b0, cpuEXEC);
      consolePulse(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);       // Continue
      checkBit("csl cont cpuCONT", 1'b1, cpuCONT);
      checkBit("csl cont cpuRUN", 1'b1, cpuRUN);
      @(negedge clk);
      checkBit("csl cont pulse end", 1'b0, cpuCONT);
      consolePulse(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);       // Breakpoint
      checkBit("csl debug cpuHALT", 1'b1, cpuHALT);
      checkBit("csl debug cpuRUN", 1'b0, cpuRUN);
   endtask

   task automatic timerAndFlags();
      int n;
      @(posedge clk);
      cslTIMEREN <= 1'b1;
      repeat (`CPU_TIMER_PERIOD + 2)
         @(negedge clk);
      checkFlags("timer while halted", 3'b000, aprFLAGS);
      consolePulse(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      n = 0;
      while (!aprFLAGS[`CPU_FLAG_TIMER] && (n < `CPU_TIMER_PERIOD + 2))
      begin
         @(negedge clk);
         n++;
      end
      checkBit("timer while running", 1'b1, aprFLAGS[`CPU_FLAG_TIMER]);
      consolePulse(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      sendCmd("timerClear", cpuPkg::opAprClear, '0, 36'h7, 0);
      repeat (`CPU_TIMER_PERIOD + 2)
         @(negedge clk);
      checkFlags("timer frozen", 3'b000, aprFLAGS);       // Counter holds while halted
      @(posedge clk);
      cslINTRI <= 1'b1;
      @(posedge clk);
      cslINTRI <= 1'b0;
      @(negedge clk);
      checkFlags("console in", CslFlag, aprFLAGS);
      sendCmd("introSet", cpuPkg::opAprWrite, '0, 36'h40, 0);
      checkBit("introSet cslINTRO", 1'b1, cslINTRO);
      sendCmd("introClear", cpuPkg::opAprWrite, '0, 36'h0, 0);
      checkBit("introClear cslINTRO", 1'b0, cslINTRO);
   endtask

   //////////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog

   initial
   begin
      repeat (TimeoutCycles)
         @(posedge clk);
      reportFail($sformatf("Timeout, run not finished after %0d cycles", TimeoutCycles));
   end

   initial
   begin
      int i;
      rstN       = 1'b0;
      cmdValid   = 1'b0;
      cmdOp      = cpuPkg::opRead;
      cmdAddr    = '0;
      cmdData    = '0;
      cpuACKI    = 1'b0;
      cpuDATAI   = '0;
      ubaINTR    = '0;
      cslRUN     = 1'b0;
      cslHALT    = 1'b0;
      cslCONT    = 1'b0;
      cslEXEC    = 1'b0;
      debugHALT  = 1'b0;
      cslTIMEREN = 1'b0;
      cslINTRI   = 1'b0;
      rowCnt     = 0;
      buildTable();
      repeat (4)
         @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      // Idle state out of reset
      checkBit("reset cpuREQO", 1'b0, cpuREQO);
      checkBit("reset rspValid", 1'b0, rspValid);
      checkBit("reset piINTR", 1'b0, piINTR);
      checkBit("reset cslINTRO", 1'b0, cslINTRO);
      checkBit("reset cpuRUN", 1'b0, cpuRUN);
      checkBit("reset cpuCONT", 1'b0, cpuCONT);
      checkBit("reset cpuEXEC", 1'b0, cpuEXEC);
      checkBit("reset cpuHALT", 1'b1, cpuHALT);
      checkBit("reset cmdReady", 1'b1, cmdReady);
      checkFlags("reset aprFLAGS", 3'b000, aprFLAGS);
      for (i = 0; i < NumRows; i++)
      begin
         @(posedge clk);
         ubaINTR <= tUba[i];
         sendCmd(tName[i], tOp[i], tAddr[i], tData[i], tDelay[i]);
         if ((tOp[i] == cpuPkg::opRead) || (tOp[i] == cpuPkg::opWrite))
         begin
            checkWord({tName[i], " rspData"}, tRsp[i], lastData);
            checkBit({tName[i], " rspNxm"}, tNxm[i], lastNxm);
         end
         checkFlags({tName[i], " aprFLAGS"}, tFlags[i], aprFLAGS);
         checkLevel({tName[i], " piREQPRI"}, tReq[i], piREQPRI);
         checkLevel({tName[i], " piCURPRI"}, tCur[i], piCURPRI);
         checkBit({tName[i], " piINTR"}, tIntr[i], piINTR);
      end
      consoleSequence();
      timerAndFlags();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire
